// File: hw/xgmac_defines.svh
`ifndef XGMAC_DEFINES_SVH
`define XGMAC_DEFINES_SVH

// Stream beat geometry
`define XGMAC_DATA_W     64
`define XGMAC_KEEP_W     8    // One enable per byte lane

// Statistics counter width
`define XGMAC_CNT_W      32

// APB geometry
`define XGMAC_APB_AW     8
`define XGMAC_APB_DW     32

// Anything shorter is a runt
`define XGMAC_MIN_FRAME  60

// Register map, byte offsets
`define XGMAC_REG_CTRL   8'h00   // Bit 0 swap enable
`define XGMAC_REG_FRAMES 8'h04   // Read only
`define XGMAC_REG_BYTES  8'h08   // Read only
`define XGMAC_REG_RUNTS  8'h0C   // Read only
`define XGMAC_REG_CLEAR  8'h10   // Write 1 to bit 0

`endif

// File: hw/xgmac_pkg.sv
`include "xgmac_defines.svh"

package xgmac_pkg;

   // One 64-bit beat of frame data
   // Byte lane n sits at bits 8n+7 down to 8n
   typedef logic [`XGMAC_DATA_W-1:0] data_t;

   // Byte enables, lane 0 goes out first
   typedef logic [`XGMAC_KEEP_W-1:0] keep_t;

   // Free-running statistics counter
   // Wraps silently at the top
   typedef logic [`XGMAC_CNT_W-1:0] cnt_t;

   // APB byte address
   typedef logic [`XGMAC_APB_AW-1:0] apb_addr_t;

endpackage

// File: hw/xgmac_address_swap.sv
`timescale 1ns/1ps

module xgmac_address_swap (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             swap_en,
   input  xgmac_pkg::data_t rx_tdata,
   input  xgmac_pkg::keep_t rx_tkeep,
   input  logic             rx_tlast,
   input  logic             rx_tvalid,
   output logic             rx_tready,
   output xgmac_pkg::data_t tx_tdata,
   output xgmac_pkg::keep_t tx_tkeep,
   output logic             tx_tlast,
   output logic             tx_tvalid,
   input  logic             tx_tready
);
   import xgmac_pkg::*;

   data_t      data_q [2];   // Two beat slots
   keep_t      keep_q [2];
   logic [1:0] last_q;
   logic       wr_ptr;       // Next free slot
   logic       rd_ptr;       // Head slot
   logic [1:0] count;        // Occupied slots
   logic       sof;          // Next beat opens a frame
   logic       second;       // Next beat is beat two of a frame
   logic       swap_frm;     // swap_en held for the current frame
   logic       push;
   logic       pop;
   logic       do_swap;
   data_t      first_raw;    // Beat one still in its slot
   data_t      first_swp;
   data_t      second_swp;

   assign push = rx_tvalid && rx_tready;
   assign pop  = tx_tvalid && tx_tready;

   // Full stalls rx unless the head leaves this cycle
   assign rx_tready = (count != 2'd2) || pop;

   // Head may leave if it closes its frame or its successor is already in
   assign tx_tvalid = (count != 2'd0) && (last_q[rd_ptr] || count == 2'd2);
   assign tx_tdata  = data_q[rd_ptr];
   assign tx_tkeep  = keep_q[rd_ptr];
   assign tx_tlast  = last_q[rd_ptr];

   // Beat one cannot have left before beat two arrives, so it is the slot behind wr_ptr
   assign first_raw = data_q[~wr_ptr];

   // Lanes 0-5 get SA bytes 6-11, lanes 6-7 get DA bytes 0-1
   assign first_swp  = {first_raw[15:0], rx_tdata[31:0], first_raw[63:48]};
   // Lanes 0-3 get DA bytes 2-5, upper half untouched
   assign second_swp = {rx_tdata[63:32], first_raw[47:16]};

   assign do_swap = push && second && swap_frm;

   // Payload slots
   always_ff @(posedge clk) begin
      if (push) begin
         data_q[wr_ptr] <= do_swap ? second_swp : rx_tdata;
         keep_q[wr_ptr] <= rx_tkeep;   // Keep and last never change
         last_q[wr_ptr] <= rx_tlast;
      end
      if (do_swap)
         data_q[~wr_ptr] <= first_swp;   // Rewrite beat one in place
   end

   // Pointers, occupancy and frame tracking
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr   <= 1'b0;
         rd_ptr   <= 1'b0;
         count    <= 2'd0;
         sof      <= 1'b1;
         second   <= 1'b0;
         swap_frm <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;   // Idle or push with pop
         endcase
         if (push) begin
            sof    <= rx_tlast;
            second <= sof && !rx_tlast;   // Single-beat frames never swap
            if (sof)
               swap_frm <= swap_en;   // Sampled once per frame
         end
      end
   end

endmodule

// File: hw/xgmac_frame_stats.sv
`timescale 1ns/1ps
`include "xgmac_defines.svh"

module xgmac_frame_stats (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             rx_beat,
   input  xgmac_pkg::keep_t rx_tkeep,
   input  logic             rx_tlast,
   input  logic             stat_clr,
   output xgmac_pkg::cnt_t  frame_cnt,
   output xgmac_pkg::cnt_t  byte_cnt,
   output xgmac_pkg::cnt_t  runt_cnt
);
   import xgmac_pkg::*;

   cnt_t       len_q;       // Bytes so far in the open frame
   cnt_t       frm_len;     // Length including this beat
   logic [3:0] beat_bytes;

   // Number of enabled lanes
   function automatic logic [3:0] popcount(input keep_t keep);
      logic [3:0] n;
      n = 4'd0;
      for (int i = 0; i < `XGMAC_KEEP_W; i++)
         n = n + {3'd0, keep[i]};
      return n;
   endfunction

   assign beat_bytes = popcount(rx_tkeep);
   assign frm_len    = len_q + cnt_t'(beat_bytes);

   always_ff @(posedge clk) begin
      if (!rst_n || stat_clr) begin   // Clear wins over a beat in the same cycle
         frame_cnt <= '0;
         byte_cnt  <= '0;
         runt_cnt  <= '0;
         len_q     <= '0;
      end else if (rx_beat) begin
         byte_cnt <= byte_cnt + cnt_t'(beat_bytes);
         if (rx_tlast) begin
            frame_cnt <= frame_cnt + 1'b1;
            if (frm_len < `XGMAC_MIN_FRAME)
               runt_cnt <= runt_cnt + 1'b1;
            len_q <= '0;   // Next frame starts fresh
         end else begin
            len_q <= frm_len;
         end
      end
   end

endmodule

// File: hw/xgmac_loopback_csr.sv
`timescale 1ns/1ps
`include "xgmac_defines.svh"

module xgmac_loopback_csr (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  xgmac_pkg::apb_addr_t     paddr,
   input  logic [`XGMAC_APB_DW-1:0] pwdata,
   output logic [`XGMAC_APB_DW-1:0] prdata,
   output logic                     pslverr,
   input  xgmac_pkg::cnt_t          frame_cnt,
   input  xgmac_pkg::cnt_t          byte_cnt,
   input  xgmac_pkg::cnt_t          runt_cnt,
   output logic                     swap_en,
   output logic                     stat_clr
);

   logic access;     // Access phase, completes this cycle
   logic wr;
   logic addr_hit;   // One of the five mapped offsets

   assign access = psel && penable;
   assign wr     = access && pwrite;

   // Error only in the access phase, never on setup
   assign pslverr = access && !addr_hit;

   // Read mux and address decode
   always_comb begin
      prdata   = '0;
      addr_hit = 1'b1;
      case (paddr)
         `XGMAC_REG_CTRL:   prdata = {{(`XGMAC_APB_DW-1){1'b0}}, swap_en};
         `XGMAC_REG_FRAMES: prdata = frame_cnt;
         `XGMAC_REG_BYTES:  prdata = byte_cnt;
         `XGMAC_REG_RUNTS:  prdata = runt_cnt;
         `XGMAC_REG_CLEAR:  prdata = '0;   // Strobe only, nothing stored
         default:           addr_hit = 1'b0;   // Unmapped reads 0
      endcase
   end

   // CTRL register
   always_ff @(posedge clk) begin
      if (!rst_n)
         swap_en <= 1'b1;   // Loopback swaps by default
      else if (wr && paddr == `XGMAC_REG_CTRL)
         swap_en <= pwdata[0];
   end

   // Clear strobe, high for the cycle after the write
   always_ff @(posedge clk) begin
      if (!rst_n)
         stat_clr <= 1'b0;
      else
         stat_clr <= wr && paddr == `XGMAC_REG_CLEAR && pwdata[0];
   end

   // FRAMES, BYTES and RUNTS writes fall through with no effect

endmodule

// File: hw/xgmac_loopback.sv
`timescale 1ns/1ps
`include "xgmac_defines.svh"

module xgmac_loopback (
   input  logic                     clk,
   input  logic                     rst_n,
   // Receive stream
   input  xgmac_pkg::data_t         rx_tdata,
   input  xgmac_pkg::keep_t         rx_tkeep,
   input  logic                     rx_tlast,
   input  logic                     rx_tvalid,
   output logic                     rx_tready,
   // Transmit stream
   output xgmac_pkg::data_t         tx_tdata,
   output xgmac_pkg::keep_t         tx_tkeep,
   output logic                     tx_tlast,
   output logic                     tx_tvalid,
   input  logic                     tx_tready,
   // APB slave
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  xgmac_pkg::apb_addr_t     paddr,
   input  logic [`XGMAC_APB_DW-1:0] pwdata,
   output logic [`XGMAC_APB_DW-1:0] prdata,
   output logic                     pslverr
);
   import xgmac_pkg::*;

   logic swap_en;    // CTRL bit 0
   logic stat_clr;   // One-cycle clear strobe
   logic rx_beat;    // Accept edge on rx
   cnt_t frame_cnt;
   cnt_t byte_cnt;
   cnt_t runt_cnt;

   // Stats sees exactly what the swapper takes
   assign rx_beat = rx_tvalid && rx_tready;

   xgmac_address_swap u_swap (
      .clk       (clk),
      .rst_n     (rst_n),
      .swap_en   (swap_en),
      .rx_tdata  (rx_tdata),
      .rx_tkeep  (rx_tkeep),
      .rx_tlast  (rx_tlast),
      .rx_tvalid (rx_tvalid),
      .rx_tready (rx_tready),
      .tx_tdata  (tx_tdata),
      .tx_tkeep  (tx_tkeep),
      .tx_tlast  (tx_tlast),
      .tx_tvalid (tx_tvalid),
      .tx_tready (tx_tready)
   );

   xgmac_frame_stats u_stats (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx_beat   (rx_beat),
      .rx_tkeep  (rx_tkeep),
      .rx_tlast  (rx_tlast),
      .stat_clr  (stat_clr),
      .frame_cnt (frame_cnt),
      .byte_cnt  (byte_cnt),
      .runt_cnt  (runt_cnt)
   );

   xgmac_loopback_csr u_csr (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pslverr   (pslverr),
      .frame_cnt (frame_cnt),
      .byte_cnt  (byte_cnt),
      .runt_cnt  (runt_cnt),
      .swap_en   (swap_en),
      .stat_clr  (stat_clr)
   );

endmodule

// File: bench/xgmac_loopback_asserts.sv
`timescale 1ns/1ps
`include "xgmac_defines.svh"

module xgmac_loopback_asserts (
   input logic                 clk,
   input logic                 rst_n,
   input xgmac_pkg::data_t     tx_tdata,
   input xgmac_pkg::keep_t     tx_tkeep,
   input logic                 tx_tlast,
   input logic                 tx_tvalid,
   input logic                 tx_tready,
   input logic                 rx_tready,
   input logic                 psel,
   input logic                 penable,
   input xgmac_pkg::apb_addr_t paddr,
   input logic                 pslverr
);

   // Stalled tx beat stays offered and unchanged
   tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
      tx_tvalid && !tx_tready |=>
         tx_tvalid && $stable(tx_tdata) && $stable(tx_tkeep) && $stable(tx_tlast))
      else $error("tx beat changed or dropped while stalled");

   // Each reset edge leaves tx empty and rx open
   reset_idle: assert property (@(posedge clk) !rst_n |=> !tx_tvalid && rx_tready)
      else $error("stream not idle after a reset edge");

   // Error response only for an access phase to an unmapped offset
   err_decode: assert property (@(posedge clk)
      pslverr == (psel && penable && !(paddr inside {`XGMAC_REG_CTRL, `XGMAC_REG_FRAMES,
         `XGMAC_REG_BYTES, `XGMAC_REG_RUNTS, `XGMAC_REG_CLEAR})))
      else $error("pslverr does not match the APB phase and address");

endmodule

bind xgmac_loopback xgmac_loopback_asserts u_asserts (.*);

// File: bench/xgmac_loopback_tb.sv
`timescale 1ns/1ps
`include "xgmac_defines.svh"

module xgmac_loopback_tb;
   import xgmac_pkg::*;

   localparam int N_SWAP  = 60;   // Frames per phase
   localparam int N_PLAIN = 40;
   localparam int N_CLR   = 20;
   // 8 beats at most per frame, 20 cycles each, plus reset and APB traffic
   localparam int WATCHDOG_CYCLES = (N_SWAP + N_PLAIN + N_CLR) * 8 * 20 + 4000;

   logic        clk = 1'b0;
   logic        rst_n, rx_tlast, rx_tvalid, rx_tready, tx_tlast, tx_tvalid, tx_tready;
   data_t       rx_tdata, tx_tdata;
   keep_t       rx_tkeep, tx_tkeep;
   logic        psel, penable, pwrite, pslverr;
   apb_addr_t   paddr;
   logic [31:0] pwdata, prdata;

   logic [31:0] lfsr;
   logic [7:0]  frm_bytes [64];      // Current frame padded to whole beats
   int          frm_len, frm_beats;
   logic        frm_swap;            // Swap flag taken at the first beat
   logic        swap_model = 1'b1;   // Last value written to CTRL
   data_t       exp_data_q [$];
   keep_t       exp_keep_q [$];
   logic        exp_last_q [$];
   cnt_t        m_frames, m_bytes, m_runts;
   logic        run_over = 1'b0;

   always #50 clk = ~clk;

   xgmac_loopback u_dut (.*);

   // Fibonacci LFSR on x^32+x^22+x^2+x+1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic stop_with_error(input string line);
      run_over = 1'b1;
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // Wire byte that lands in output byte k when DA and SA trade places
   function automatic int src_index(input int k);
      if (k < 6)
         return k + 6;
      if (k < 12)
         return k - 6;
      return k;
   endfunction

   function automatic data_t beat_data(input int b, input logic swap);
      data_t d;
      int    k;
      for (int i = 0; i < 8; i++) begin
         k = 8 * b + i;
         if (swap && frm_beats > 1)
            k = src_index(k);   // Single-beat frames pass as they are
         d[8*i +: 8] = frm_bytes[k];
      end
      return d;
   endfunction

   function automatic keep_t beat_keep(input int b);
      keep_t kp;
      for (int i = 0; i < 8; i++)
         kp[i] = (8 * b + i < frm_len);
      return kp;
   endfunction

   task automatic make_frame();
      logic [31:0] r;
      r = rand_bits(3);
      if (r == 0)
         frm_len = 56 + int'(rand_bits(3));   // Either side of the runt limit
      else
         frm_len = 1 + int'(rand_bits(6) % 40);
      frm_beats = (frm_len + 7) / 8;
      for (int k = 0; k < 8 * frm_beats; k++) begin
         r = rand_bits(8);
         frm_bytes[k] = r[7:0];
      end
   endtask

   // Expected tx beat and counters at rx accept
   task automatic model_accept(input int b);
      logic last;
      last = (b == frm_beats - 1);
      if (b == 0)
         frm_swap = swap_model;
      exp_data_q.push_back(beat_data(b, frm_swap));
      exp_keep_q.push_back(beat_keep(b));
      exp_last_q.push_back(last);
      if (last) begin
         m_frames = m_frames + 1;
         m_bytes  = m_bytes + cnt_t'(frm_len);
         if (frm_len < `XGMAC_MIN_FRAME)
            m_runts = m_runts + 1;
      end
   endtask

   task automatic check_tx();
      assert (exp_data_q.size() != 0)
         else stop_with_error($sformatf("ERR %0t: tx beat with none expected", $time));
      assert (tx_tdata == exp_data_q[0] && tx_tkeep == exp_keep_q[0] && tx_tlast == exp_last_q[0])
         else stop_with_error($sformatf("ERR %0t: tx %h/%h/%0b expected %h/%h/%0b", $time,
            tx_tdata, tx_tkeep, tx_tlast, exp_data_q[0], exp_keep_q[0], exp_last_q[0]));
      void'(exp_data_q.pop_front());
      void'(exp_keep_q.pop_front());
      void'(exp_last_q.pop_front());
   endtask

   // Sends n frames with rx gaps and tx stalls until all of them are back
   task automatic run_frames(input int n);
      int          sent, beat;
      logic        have, rx_acc, tx_acc;
      logic [31:0] r;
      sent   = 0;
      beat   = 0;
      have   = 1'b0;
      rx_acc = 1'b0;
      while (sent < n || exp_data_q.size() != 0) begin
         @(negedge clk);
         if (rx_acc) begin
            beat = beat + 1;
            if (beat == frm_beats) begin
               sent = sent + 1;
               have = 1'b0;
            end
         end
         if (!have && sent < n) begin
            make_frame();
            have = 1'b1;
            beat = 0;
         end
         if (!rx_tvalid || rx_acc) begin   // An offered beat holds until taken
            r = rand_bits(2);
            rx_tvalid = have && r != 0;
            rx_tdata  = beat_data(beat, 1'b0);
            rx_tkeep  = beat_keep(beat);
            rx_tlast  = (beat == frm_beats - 1);
         end
         r = rand_bits(2);
         tx_tready = (r != 0);   // Stall about one cycle in four
         #1;
         rx_acc = rx_tvalid && rx_tready;
         tx_acc = tx_tvalid && tx_tready;
         if (rx_acc)
            model_accept(beat);
         if (tx_acc)
            check_tx();
      end
      @(negedge clk);
      tx_tready = 1'b0;   // Parked so nothing leaves between phases
      #1;
      assert (!tx_tvalid)
         else stop_with_error($sformatf("ERR %0t: extra tx beat after the drain", $time));
   endtask

   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;   // Setup
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;   // Access completes at the next rising edge
      #1;
      rdata   = prdata;
      err     = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic reg_write(input apb_addr_t addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, data, rd, err);
      assert (err == exp_err)
         else stop_with_error($sformatf("ERR %0t: write %h gave pslverr %0b", $time, addr, err));
   endtask

   task automatic reg_expect(input apb_addr_t addr, input logic [31:0] exp, input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, addr, 32'h0, rd, err);
      assert (rd == exp && err == exp_err)
         else stop_with_error($sformatf("ERR %0t: read %h gave %h/%0b expected %h/%0b",
            $time, addr, rd, err, exp, exp_err));
   endtask

   task automatic check_counts();
      reg_expect(`XGMAC_REG_FRAMES, m_frames, 1'b0);
      reg_expect(`XGMAC_REG_BYTES, m_bytes, 1'b0);
      reg_expect(`XGMAC_REG_RUNTS, m_runts, 1'b0);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * 100);
      stop_with_error("Watchdog expired before all frames came back");
   end

   // A failing bound assertion ends the run here
   final begin
      if (!run_over)
         $display("TEST FAILED");
   end

   initial begin
      rst_n     = 1'b0;
      rx_tdata  = '0;
      rx_tkeep  = '0;
      rx_tlast  = 1'b0;
      rx_tvalid = 1'b0;
      tx_tready = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      lfsr      = 32'h6a4;
      m_frames  = '0;
      m_bytes   = '0;
      m_runts   = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      assert (!tx_tvalid && rx_tready && !pslverr)
         else stop_with_error($sformatf("ERR %0t: outputs not idle after reset", $time));
      reg_expect(`XGMAC_REG_CTRL, 32'h1, 1'b0);   // Swap on by default

      run_frames(N_SWAP);
      check_counts();

      reg_write(`XGMAC_REG_CTRL, 32'h0, 1'b0);
      swap_model = 1'b0;
      reg_expect(`XGMAC_REG_CTRL, 32'h0, 1'b0);
      run_frames(N_PLAIN);   // Straight loopback
      check_counts();

      reg_write(`XGMAC_REG_FRAMES, 32'hffff_ffff, 1'b0);   // Read only
      reg_write(`XGMAC_REG_BYTES, 32'h0, 1'b0);
      check_counts();
      reg_expect(8'h14, 32'h0, 1'b1);   // First hole past CLEAR
      reg_write(8'hfc, 32'h1, 1'b1);
      reg_expect(`XGMAC_REG_CLEAR, 32'h0, 1'b0);

      reg_write(`XGMAC_REG_CLEAR, 32'h1, 1'b0);
      m_frames = '0;
      m_bytes  = '0;
      m_runts  = '0;
      check_counts();
      reg_write(`XGMAC_REG_CTRL, 32'h1, 1'b0);
      swap_model = 1'b1;
      run_frames(N_CLR);   // Counting again from zero
      check_counts();

      run_over = 1'b1;
      $display("TEST OK");
      $finish;
   end

endmodule

// File: sim.f
+incdir+hw
hw/xgmac_pkg.sv
hw/xgmac_address_swap.sv
hw/xgmac_frame_stats.sv
hw/xgmac_loopback_csr.sv
hw/xgmac_loopback.sv
bench/xgmac_loopback_asserts.sv
bench/xgmac_loopback_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the loopback testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module xgmac_loopback_tb -o xgmac_loopback_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/xgmac_loopback_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
